//--- common/stbuf_cfg_pkg.sv
package stbuf_cfg_pkg;

   // --------------------------------------------------
   // buffer geometry
   // --------------------------------------------------
   localparam int STBUF_DEPTH = 8;                       // number of entries
   localparam int STBUF_PTR_W = $clog2(STBUF_DEPTH);     // read/write pointer width
   localparam int STBUF_CNT_W = STBUF_PTR_W + 1;         // occupancy count, holds 0..DEPTH

   // --------------------------------------------------
   // address and data geometry
   // --------------------------------------------------
   localparam int ADDR_W         = 16;                   // byte address
   localparam int DATA_W         = 32;
   localparam int BYTES_PER_WORD = DATA_W / 8;

   // byte offset inside one word
   localparam int BYTE_OFS_W = $clog2(BYTES_PER_WORD);

   // word address, the part compared for coalescing and forwarding
   localparam int WADDR_W = ADDR_W - BYTE_OFS_W;

endpackage

//--- common/stbuf_types_pkg.sv
package stbuf_types_pkg;

   import stbuf_cfg_pkg::*;

   // --------------------------------------------------
   // store access size
   // --------------------------------------------------
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,                                  // 1 byte
      SIZE_HALF = 2'd1,                                  // 2 bytes
      SIZE_WORD = 2'd2                                   // 4 bytes
   } st_size_e;

   // --------------------------------------------------
   // one data word, two views of the same bits
   // --------------------------------------------------
   // bytes[0] is the lowest addressed byte, bits 7:0 of word
   typedef union packed {
      logic [DATA_W-1:0]                 word;           // drain and forwarding
      logic [BYTES_PER_WORD-1:0][7:0]    bytes;          // byte merge
   } stbuf_word_u;

endpackage

//--- stbuf/stbuf_alloc.sv
module stbuf_alloc
   import stbuf_cfg_pkg::*;
(
   input  logic                                clk,
   input  logic                                rst,

   // store side
   input  logic                                st_valid,
   output logic                                st_ready,
   input  logic [WADDR_W-1:0]                  st_waddr,
   input  logic [STBUF_DEPTH-1:0][WADDR_W-1:0] entry_waddr,

   // drain side
   input  logic                                drain_ready,
   output logic                                drain_valid,

   output logic [STBUF_DEPTH-1:0]              vld,
   output logic [STBUF_PTR_W-1:0]              rd_ptr,
   output logic [STBUF_DEPTH-1:0]              entry_wr_en,
   output logic [STBUF_DEPTH-1:0]              entry_clr,
   output logic                                stbuf_full,
   output logic                                stbuf_empty
);

   logic [STBUF_PTR_W-1:0] wr_ptr;
   logic [STBUF_CNT_W-1:0] cnt;                          // live entries
   logic [STBUF_DEPTH-1:0] match;                        // coalesce candidates
   logic                   st_fire;
   logic                   rel_fire;
   logic                   coalesce;
   logic                   alloc_new;

   // --------------------------------------------------
   // handshakes
   // --------------------------------------------------
   assign st_ready    = (cnt < STBUF_CNT_W'(STBUF_DEPTH));
   assign st_fire     = st_valid & st_ready;
   assign drain_valid = vld[rd_ptr];                     // head entry live
   assign rel_fire    = drain_valid & drain_ready;

   // --------------------------------------------------
   // coalesce match and per-entry enables
   // --------------------------------------------------
   for (genvar i = 0; i < STBUF_DEPTH; i++) begin : g_entry
      assign entry_clr[i] = rel_fire & (rd_ptr == STBUF_PTR_W'(i));

      // head leaving this cycle can not take new bytes
      assign match[i] = vld[i] & ~entry_clr[i] & (entry_waddr[i] == st_waddr);

      assign entry_wr_en[i] = (st_fire & match[i]) |
                              (alloc_new & (wr_ptr == STBUF_PTR_W'(i)));
   end

   assign coalesce  = |match;                            // at most one bit set
   assign alloc_new = st_fire & ~coalesce;

   // --------------------------------------------------
   // valid bits, pointers, count
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         vld    <= '0;
         wr_ptr <= '0;
         rd_ptr <= '0;
         cnt    <= '0;
      end else begin
         vld <= (vld & ~entry_clr) | entry_wr_en;
         if (alloc_new) begin
            wr_ptr <= wr_ptr + STBUF_PTR_W'(1);
         end
         if (rel_fire) begin
            rd_ptr <= rd_ptr + STBUF_PTR_W'(1);
         end
         case ({alloc_new, rel_fire})
            2'b10:   cnt <= cnt + STBUF_CNT_W'(1);
            2'b01:   cnt <= cnt - STBUF_CNT_W'(1);
            default: cnt <= cnt;                         // none, or alloc and release together
         endcase
      end
   end

   assign stbuf_full  = (cnt == STBUF_CNT_W'(STBUF_DEPTH));
   assign stbuf_empty = (cnt == '0);

endmodule

//--- stbuf/stbuf_entries.sv
module stbuf_entries
   import stbuf_cfg_pkg::*;
   import stbuf_types_pkg::*;
(
   input  logic                                       clk,
   input  logic                                       rst,

   // incoming store
   input  logic [ADDR_W-1:0]                          st_addr,
   input  st_size_e                                   st_size,
   input  stbuf_word_u                                st_data,

   // from allocation
   input  logic [STBUF_DEPTH-1:0]                     entry_wr_en,
   input  logic [STBUF_DEPTH-1:0]                     entry_clr,
   input  logic [STBUF_PTR_W-1:0]                     rd_ptr,

   // entry contents
   output logic [STBUF_DEPTH-1:0][WADDR_W-1:0]        entry_waddr,
   output logic [STBUF_DEPTH-1:0][BYTES_PER_WORD-1:0] entry_byteen,
   output stbuf_word_u [STBUF_DEPTH-1:0]              entry_data,

   // head entry
   output logic [ADDR_W-1:0]                          drain_addr,
   output logic [BYTES_PER_WORD-1:0]                  drain_byteen,
   output stbuf_word_u                                drain_data
);

   logic [BYTES_PER_WORD-1:0] size_mask;
   logic [BYTES_PER_WORD-1:0] st_byteen;

   // --------------------------------------------------
   // store byte enable
   // --------------------------------------------------
   always_comb begin
      case (st_size)
         SIZE_BYTE: size_mask = 4'b0001;
         SIZE_HALF: size_mask = 4'b0011;
         default:   size_mask = 4'b1111;
      endcase
   end

   // bits shifted past byte 3 fall off
   assign st_byteen = size_mask << st_addr[BYTE_OFS_W-1:0];

   // --------------------------------------------------
   // address and data, merged byte by byte
   // --------------------------------------------------
   always_ff @(posedge clk) begin
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         if (entry_wr_en[i]) begin
            entry_waddr[i] <= st_addr[ADDR_W-1:BYTE_OFS_W];
            for (int j = 0; j < BYTES_PER_WORD; j++) begin
               if (st_byteen[j]) begin
                  entry_data[i].bytes[j] <= st_data.bytes[j];   // newer store wins
               end
            end
         end
      end
   end

   // byte enables accumulate until the entry drains
   always_ff @(posedge clk) begin
      if (rst) begin
         entry_byteen <= '0;
      end else begin
         for (int i = 0; i < STBUF_DEPTH; i++) begin
            if (entry_wr_en[i]) begin
               entry_byteen[i] <= entry_byteen[i] | st_byteen;
            end else if (entry_clr[i]) begin
               entry_byteen[i] <= '0;
            end
         end
      end
   end

   // head entry out, word address back to byte address
   assign drain_addr   = {entry_waddr[rd_ptr], {BYTE_OFS_W{1'b0}}};
   assign drain_byteen = entry_byteen[rd_ptr];
   assign drain_data   = entry_data[rd_ptr];

endmodule

//--- source/stbuf_fwd.sv
module stbuf_fwd
   import stbuf_cfg_pkg::*;
   import stbuf_types_pkg::*;
(
   input  logic [WADDR_W-1:0]                         ld_waddr,
   input  logic [STBUF_DEPTH-1:0]                     vld,
   input  logic [STBUF_DEPTH-1:0][WADDR_W-1:0]        entry_waddr,
   input  logic [STBUF_DEPTH-1:0][BYTES_PER_WORD-1:0] entry_byteen,
   input  stbuf_word_u [STBUF_DEPTH-1:0]              entry_data,
   output logic [BYTES_PER_WORD-1:0]                  fwd_byteen,
   output stbuf_word_u                                fwd_data
);

   logic              hit;
   logic [DATA_W-1:0] byte_mask;                         // enables widened to bits

   // --------------------------------------------------
   // load lookup over all entries
   // --------------------------------------------------
   // only one live entry can hold a given word, so OR is enough
   always_comb begin
      fwd_byteen    = '0;
      fwd_data.word = '0;
      hit           = 1'b0;
      byte_mask     = '0;
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         hit = vld[i] & (entry_waddr[i] == ld_waddr);
         for (int j = 0; j < BYTES_PER_WORD; j++) begin
            byte_mask[8*j +: 8] = {8{hit & entry_byteen[i][j]}};
         end
         fwd_byteen    = fwd_byteen | ({BYTES_PER_WORD{hit}} & entry_byteen[i]);
         fwd_data.word = fwd_data.word | (byte_mask & entry_data[i].word);
      end
   end

endmodule

//--- source/stbuf_top.sv
module stbuf_top
   import stbuf_cfg_pkg::*;
   import stbuf_types_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst,

   // store port
   input  logic                      st_valid,
   output logic                      st_ready,
   input  logic [ADDR_W-1:0]         st_addr,
   input  st_size_e                  st_size,
   input  stbuf_word_u               st_data,

   // drain port
   output logic                      drain_valid,
   input  logic                      drain_ready,
   output logic [ADDR_W-1:0]         drain_addr,
   output logic [BYTES_PER_WORD-1:0] drain_byteen,
   output stbuf_word_u               drain_data,

   // load lookup
   input  logic [WADDR_W-1:0]        ld_waddr,
   output logic [BYTES_PER_WORD-1:0] fwd_byteen,
   output stbuf_word_u               fwd_data,

   output logic                      stbuf_full,
   output logic                      stbuf_empty
);

   logic [STBUF_DEPTH-1:0]                     vld;
   logic [STBUF_PTR_W-1:0]                     rd_ptr;
   logic [STBUF_DEPTH-1:0]                     entry_wr_en;
   logic [STBUF_DEPTH-1:0]                     entry_clr;
   logic [STBUF_DEPTH-1:0][WADDR_W-1:0]        entry_waddr;
   logic [STBUF_DEPTH-1:0][BYTES_PER_WORD-1:0] entry_byteen;
   stbuf_word_u [STBUF_DEPTH-1:0]              entry_data;

   // --------------------------------------------------
   // allocation and pointers
   // --------------------------------------------------
   stbuf_alloc alloc_i (
      .clk         (clk),
      .rst         (rst),
      .st_valid    (st_valid),
      .st_ready    (st_ready),
      .st_waddr    (st_addr[ADDR_W-1:BYTE_OFS_W]),
      .entry_waddr (entry_waddr),
      .drain_ready (drain_ready),
      .drain_valid (drain_valid),
      .vld         (vld),
      .rd_ptr      (rd_ptr),
      .entry_wr_en (entry_wr_en),
      .entry_clr   (entry_clr),
      .stbuf_full  (stbuf_full),
      .stbuf_empty (stbuf_empty)
   );

   // --------------------------------------------------
   // entry storage and merge
   // --------------------------------------------------
   stbuf_entries entries_i (
      .clk          (clk),
      .rst          (rst),
      .st_addr      (st_addr),
      .st_size      (st_size),
      .st_data      (st_data),
      .entry_wr_en  (entry_wr_en),
      .entry_clr    (entry_clr),
      .rd_ptr       (rd_ptr),
      .entry_waddr  (entry_waddr),
      .entry_byteen (entry_byteen),
      .entry_data   (entry_data),
      .drain_addr   (drain_addr),
      .drain_byteen (drain_byteen),
      .drain_data   (drain_data)
   );

   // load forwarding, same cycle
   stbuf_fwd fwd_i (
      .ld_waddr     (ld_waddr),
      .vld          (vld),
      .entry_waddr  (entry_waddr),
      .entry_byteen (entry_byteen),
      .entry_data   (entry_data),
      .fwd_byteen   (fwd_byteen),
      .fwd_data     (fwd_data)
   );

endmodule

//--- test/stbuf_props.sv
module stbuf_props
   import stbuf_cfg_pkg::*;
(
   input logic                      clk,
   input logic                      rst,
   input logic                      st_valid,
   input logic                      st_ready,
   input logic [ADDR_W-1:0]         st_addr,
   input logic                      drain_valid,
   input logic                      drain_ready,
   input logic [ADDR_W-1:0]         drain_addr,
   input logic [BYTES_PER_WORD-1:0] drain_byteen,
   input logic [DATA_W-1:0]         drain_data,
   input logic                      stbuf_full,
   input logic                      stbuf_empty
);

   logic head_merge;                                     // store coalescing into the head

   assign head_merge = st_valid & st_ready &
                       (st_addr[ADDR_W-1:BYTE_OFS_W] == drain_addr[ADDR_W-1:BYTE_OFS_W]);

   // --------------------------------------------------
   // drain and fullness rules
   // --------------------------------------------------
   a_valid_not_empty: assert property (@(posedge clk) disable iff (rst)
      !(drain_valid && stbuf_empty))
      else $error("drain_valid high while the buffer is empty");

   // a full buffer also has a live head to drain
   a_full_blocks_store: assert property (@(posedge clk) disable iff (rst)
      stbuf_full |-> !st_ready && drain_valid)
      else $error("full buffer with st_ready high or no live head entry");

   // head may only change its bytes by a merge
   a_drain_hold: assert property (@(posedge clk) disable iff (rst)
      drain_valid && !drain_ready && !head_merge |=>
         $stable(drain_addr) && $stable(drain_byteen) && $stable(drain_data))
      else $error("drain outputs changed while stalled");

endmodule

bind stbuf_top stbuf_props props_i (.*);

//--- test/stbuf_tb.sv
module stbuf_tb
   import stbuf_cfg_pkg::*;
   import stbuf_types_pkg::*;
();

   localparam int MAX_CYCLES = 2000;                     // about four times the test length
   localparam int N_RANDOM   = 200;

   logic                      clk;
   logic                      rst;
   logic                      st_valid;
   logic                      st_ready;
   logic [ADDR_W-1:0]         st_addr;
   st_size_e                  st_size;
   stbuf_word_u               st_data;
   logic                      drain_valid;
   logic                      drain_ready;
   logic [ADDR_W-1:0]         drain_addr;
   logic [BYTES_PER_WORD-1:0] drain_byteen;
   stbuf_word_u               drain_data;
   logic [WADDR_W-1:0]        ld_waddr;
   logic [BYTES_PER_WORD-1:0] fwd_byteen;
   stbuf_word_u               fwd_data;
   logic                      stbuf_full;
   logic                      stbuf_empty;

   // reference model, entries in allocation order
   logic [WADDR_W-1:0]        m_waddr[$];
   logic [BYTES_PER_WORD-1:0] m_be[$];
   stbuf_word_u               m_data[$];

   int errors    = 0;
   int checks    = 0;
   int n_drained = 0;
   int cycles    = 0;
   int seed;

   stbuf_top dut_i (.*);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout: tests still running after %0d cycles", MAX_CYCLES);
         $display("*** FAILED ***");
         $finish;
      end
   end

   // releases seen at the DUT drain port
   always @(posedge clk) begin
      if (!rst && drain_valid && drain_ready) begin
         n_drained <= n_drained + 1;
      end
   end

   // --------------------------------------------------
   // compare tasks
   // --------------------------------------------------
   task automatic check_word(input string name, input stbuf_word_u exp, input stbuf_word_u act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] t=%0t %s expected %08h actual %08h", $time, name, exp.word, act.word);
      end
   endtask

   task automatic check_byteen(input string name, input logic [BYTES_PER_WORD-1:0] exp,
                               input logic [BYTES_PER_WORD-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] t=%0t %s expected %h actual %h", $time, name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input logic [ADDR_W-1:0] exp,
                             input logic [ADDR_W-1:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] t=%0t %s expected %04h actual %04h", $time, name, exp, act);
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, exp, act);
      end
   endtask

   // --------------------------------------------------
   // model helpers
   // --------------------------------------------------
   function automatic logic [WADDR_W-1:0] waddr_of(input logic [ADDR_W-1:0] a);
      return a[ADDR_W-1:BYTE_OFS_W];
   endfunction

   // size mask moved up to the byte offset, bits past byte 3 dropped
   function automatic logic [BYTES_PER_WORD-1:0] store_byteen(input st_size_e s,
                                                              input logic [BYTE_OFS_W-1:0] ofs);
      logic [BYTES_PER_WORD-1:0] mask;
      case (s)
         SIZE_BYTE: mask = 4'h1;
         SIZE_HALF: mask = 4'h3;
         default:   mask = 4'hF;
      endcase
      return mask << ofs;
   endfunction

   function automatic stbuf_word_u keep_enabled(input stbuf_word_u w,
                                                input logic [BYTES_PER_WORD-1:0] be);
      stbuf_word_u r;
      r.word = '0;
      for (int j = 0; j < BYTES_PER_WORD; j++) begin
         if (be[j]) begin
            r.bytes[j] = w.bytes[j];
         end
      end
      return r;
   endfunction

   // outputs against the model, sampled mid cycle
   task automatic check_state();
      int                        n;
      logic [BYTES_PER_WORD-1:0] exp_be;
      stbuf_word_u               exp_data;
      stbuf_word_u               tmp;
      n = m_waddr.size();
      check_bit("stbuf_empty", n == 0, stbuf_empty);
      check_bit("stbuf_full", n == STBUF_DEPTH, stbuf_full);
      check_bit("st_ready", n < STBUF_DEPTH, st_ready);
      check_bit("drain_valid", n > 0, drain_valid);
      if (n > 0) begin
         check_addr("drain_addr", {m_waddr[0], {BYTE_OFS_W{1'b0}}}, drain_addr);
         check_byteen("drain_byteen", m_be[0], drain_byteen);
         check_word("drain_data", m_data[0], keep_enabled(drain_data, m_be[0]));
      end
      exp_be        = '0;
      exp_data.word = '0;
      for (int k = 0; k < n; k++) begin
         tmp = m_data[k];
         if (m_waddr[k] == ld_waddr) begin
            exp_be        = exp_be | m_be[k];
            exp_data.word = exp_data.word | tmp.word;
         end
      end
      check_byteen("fwd_byteen", exp_be, fwd_byteen);
      check_word("fwd_data", exp_data, fwd_data);
   endtask

   // what the coming edge does: release first, then merge or allocate
   task automatic update_model(input logic v, input logic [ADDR_W-1:0] a, input st_size_e s,
                               input stbuf_word_u d, input logic dr);
      logic [BYTES_PER_WORD-1:0] be;
      stbuf_word_u               w;
      int                        k;
      logic                      take;
      take = v && (m_waddr.size() < STBUF_DEPTH);       // room before this edge
      if (dr && m_waddr.size() > 0) begin
         m_waddr.delete(0);
         m_be.delete(0);
         m_data.delete(0);
      end
      if (take) begin
         be = store_byteen(s, a[BYTE_OFS_W-1:0]);
         k  = -1;
         for (int i = 0; i < m_waddr.size(); i++) begin
            if (m_waddr[i] == waddr_of(a)) begin
               k = i;
            end
         end
         if (k < 0) begin                                // fresh entry, empty enables
            w.word = '0;
            m_waddr.push_back(waddr_of(a));
            m_be.push_back('0);
            m_data.push_back(w);
            k = m_waddr.size() - 1;
         end
         w = m_data[k];
         for (int j = 0; j < BYTES_PER_WORD; j++) begin
            if (be[j]) begin
               w.bytes[j] = d.bytes[j];                  // newer store wins
            end
         end
         m_data[k] = w;
         m_be[k]   = m_be[k] | be;
      end
   endtask

   // one clock: drive on the rising edge, check at the falling edge
   task automatic step(input logic v, input logic [ADDR_W-1:0] a, input st_size_e s,
                       input logic [DATA_W-1:0] d, input logic dr, input logic [WADDR_W-1:0] ldw);
      stbuf_word_u dw;
      dw.word = d;
      @(posedge clk);
      st_valid    <= v;
      st_addr     <= a;
      st_size     <= s;
      st_data     <= dw;
      drain_ready <= dr;
      ld_waddr    <= ldw;
      @(negedge clk);
      check_state();
      update_model(v, a, s, dw, dr);
   endtask

   task automatic idle(input logic dr, input logic [WADDR_W-1:0] ldw);
      step(1'b0, '0, SIZE_BYTE, '0, dr, ldw);
   endtask

   task automatic send_store(input logic [ADDR_W-1:0] a, input st_size_e s,
                             input logic [DATA_W-1:0] d, input logic dr);
      do begin
         step(1'b1, a, s, d, dr, waddr_of(a));
      end while (!st_ready);                             // accepted on the next edge
   endtask

   task automatic drain_all();
      idle(1'b1, '0);
      while (!stbuf_empty) begin
         idle(1'b1, '0);
      end
      idle(1'b0, '0);
   endtask

   // --------------------------------------------------
   // directed tests
   // --------------------------------------------------
   task automatic test_reset();
      idle(1'b0, waddr_of(16'h1000));
      check_bit("stbuf_empty", 1'b1, stbuf_empty);
      check_bit("st_ready", 1'b1, st_ready);
      check_byteen("fwd_byteen", 4'h0, fwd_byteen);
   endtask

   task automatic test_in_order();
      send_store(16'h1001, SIZE_BYTE, 32'h0000_5A00, 1'b1);
      send_store(16'h1102, SIZE_HALF, 32'hBEEF_0000, 1'b1);
      send_store(16'h1200, SIZE_WORD, 32'h1234_5678, 1'b1);
      send_store(16'h1303, SIZE_BYTE, 32'hC300_0000, 1'b1);
      drain_all();
   endtask

   task automatic test_coalesce();
      int n0;
      n0 = n_drained;
      send_store(16'h2001, SIZE_BYTE, 32'h0000_AA00, 1'b0);
      send_store(16'h2000, SIZE_HALF, 32'h0000_BBCC, 1'b0);
      idle(1'b0, waddr_of(16'h2000));
      check_byteen("drain_byteen", 4'h3, drain_byteen);
      check_word("fwd_data", 32'h0000_BBCC, fwd_data); // byte 1 from the half store
      drain_all();
      if (n_drained - n0 != 1) begin
         errors++;
         $display("coalesce: two stores to one word drained as %0d entries", n_drained - n0);
      end
   endtask

   task automatic test_full();
      for (int i = 0; i < STBUF_DEPTH; i++) begin
         send_store(ADDR_W'(16'h3000 + 4 * i), SIZE_WORD, 32'h3000_0000 + i, 1'b0);
      end
      idle(1'b0, waddr_of(16'h3000));
      check_bit("stbuf_full", 1'b1, stbuf_full);
      check_bit("st_ready", 1'b0, st_ready);
      repeat (2) step(1'b1, 16'h3100, SIZE_WORD, 32'h3100_0009, 1'b0, '0);  // ninth waits
      send_store(16'h3100, SIZE_WORD, 32'h3100_0009, 1'b1);
      drain_all();
   endtask

   task automatic test_forward();
      send_store(16'h4000, SIZE_WORD, 32'h1122_3344, 1'b0);
      send_store(16'h4403, SIZE_BYTE, 32'h5500_0000, 1'b0);
      idle(1'b0, waddr_of(16'h4000));
      check_byteen("fwd_byteen", 4'hF, fwd_byteen);
      check_word("fwd_data", 32'h1122_3344, fwd_data);
      idle(1'b0, waddr_of(16'h4403));
      check_byteen("fwd_byteen", 4'h8, fwd_byteen);
      check_word("fwd_data", 32'h5500_0000, fwd_data);
      idle(1'b0, waddr_of(16'h7FF0));                     // absent word
      check_byteen("fwd_byteen", 4'h0, fwd_byteen);
      check_word("fwd_data", 32'h0, fwd_data);
      drain_all();
   endtask

   task automatic test_random();
      logic [ADDR_W-1:0] a;
      logic [DATA_W-1:0] d;
      st_size_e          s;
      int                r;
      for (int n = 0; n < N_RANDOM; n++) begin
         r = $random(seed) & 32'h7FFF_FFFF;
         case (r % 3)
            0:       s = SIZE_BYTE;
            1:       s = SIZE_HALF;
            default: s = SIZE_WORD;
         endcase
         a = ADDR_W'(16'h0800 + 4 * ((r >> 4) % 9));     // nine words, can fill the buffer
         if (s == SIZE_BYTE) begin
            a[1:0] = r[9:8];
         end else if (s == SIZE_HALF) begin
            a[1:0] = {r[8], 1'b0};
         end
         d = $random(seed);
         do begin
            r = $random(seed) & 32'h7FFF_FFFF;
            step(1'b1, a, s, d, r[0], WADDR_W'(32'h200 + (r >> 1) % 10));
         end while (!st_ready);
      end
      drain_all();
   endtask

   initial begin
      seed        = 39671;
      rst         = 1'b1;
      st_valid    = 1'b0;
      st_addr     = '0;
      st_size     = SIZE_BYTE;
      st_data     = '0;
      drain_ready = 1'b0;
      ld_waddr    = '0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;
      test_reset();
      test_in_order();
      test_coalesce();
      test_full();
      test_forward();
      test_random();
      $display("errors: %0d in %0d checks", errors, checks);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

//--- compile.f
common/stbuf_cfg_pkg.sv
common/stbuf_types_pkg.sv
stbuf/stbuf_alloc.sv
stbuf/stbuf_entries.sv
source/stbuf_fwd.sv
source/stbuf_top.sv
test/stbuf_props.sv
test/stbuf_tb.sv

//--- Makefile
VERILATOR  = verilator
VFLAGS     = --binary --timing --assert
LINT_FLAGS = --lint-only -Wall --timing --assert
TOP        = stbuf_tb
FILELIST   = compile.f
OBJ_DIR    = obj_dir
PASS_MSG   = *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
